// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_sw_align \
	-o sim_tb || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -qx "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic o_clk,
	output logic o_rst_n
);

	// 8 ns period
	initial begin
		o_clk = 1'b0;
		forever #4 o_clk = ~o_clk;
	end

	// Reset held for 3 cycles, released away from the rising edge
	initial begin
		o_rst_n = 1'b0;
		repeat (3) @(posedge o_clk);
		@(negedge o_clk);
		o_rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tests/tb_sw_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sw_align
	import sw_score_pkg::*;
	import sw_array_pkg::*;
();

	localparam int RAND_JOBS  = 40;
	localparam int NUM_JOBS   = 48;
	localparam int TOTAL_RUNS = 2 * RAND_JOBS + 8;
	localparam int WAIT_LIMIT = PE_COUNT + 12;
	// Worst case with a stall of up to 4 cycles before every base
	localparam int MAX_JOB_CYCLES = 2 + MAX_T_LEN * 5 + WAIT_LIMIT;
	localparam int WATCHDOG_NS    = (TOTAL_RUNS * MAX_JOB_CYCLES + 50) * 8;
	localparam int TOP_SCORE      = (1 << SCORE_W) - 1;

	logic                 clk;
	logic                 rst_n;
	logic                 i_start;
	base_t [PE_COUNT-1:0] i_query;
	logic  [LEN_W-1:0]    i_query_len;
	score_t               i_match;
	score_t               i_mismatch;
	score_t               i_alpha;
	score_t               i_beta;
	base_t                i_t_base;
	logic                 i_t_valid;
	logic                 i_t_last;
	logic                 o_busy;
	logic                 o_valid;
	score_t               o_score;

	logic [15:0] lfsr_state;
	int          errors;
	int          jobs_run;

	// Job table
	int jq_len  [NUM_JOBS];
	int jt_len  [NUM_JOBS];
	int jq      [NUM_JOBS][PE_COUNT];
	int jt      [NUM_JOBS][MAX_T_LEN];
	int j_match [NUM_JOBS];
	int j_mis   [NUM_JOBS];
	int j_alpha [NUM_JOBS];
	int j_beta  [NUM_JOBS];

	tb_clk_gen u_clk_gen (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	sw_align_top uut (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_start     (i_start),
		.i_query     (i_query),
		.i_query_len (i_query_len),
		.i_match     (i_match),
		.i_mismatch  (i_mismatch),
		.i_alpha     (i_alpha),
		.i_beta      (i_beta),
		.i_t_base    (i_t_base),
		.i_t_valid   (i_t_valid),
		.i_t_last    (i_t_last),
		.o_busy      (o_busy),
		.o_valid     (o_valid),
		.o_score     (o_score)
	);

	// Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
	function int take_bits(input int n);
		int v;
		v = 0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
			v = (v << 1) | int'(lfsr_state[0]);
		end
		return v;
	endfunction

	function automatic int clamp_score(input int v);
		if (v < 0) begin
			return 0;
		end
		return (v > TOP_SCORE) ? TOP_SCORE : v;
	endfunction

	function automatic int larger(input int a, input int b);
		return (a > b) ? a : b;
	endfunction

	// Affine-gap local alignment with rows along the query
	function automatic int model_score(input int idx);
		int h [PE_COUNT+1][MAX_T_LEN+1];
		int e [PE_COUNT+1][MAX_T_LEN+1];
		int f [PE_COUNT+1][MAX_T_LEN+1];
		int diag;
		int best;
		h = '{default: '{default: 0}};
		e = '{default: '{default: 0}};
		f = '{default: '{default: 0}};
		best = 0;
		for (int i = 1; i <= jq_len[idx]; i++) begin
			for (int j = 1; j <= jt_len[idx]; j++) begin
				e[i][j] = larger(clamp_score(h[i][j-1] - j_alpha[idx]),
					clamp_score(e[i][j-1] - j_beta[idx]));
				f[i][j] = larger(clamp_score(h[i-1][j] - j_alpha[idx]),
					clamp_score(f[i-1][j] - j_beta[idx]));
				if (jq[idx][i-1] == jt[idx][j-1]) begin
					diag = clamp_score(h[i-1][j-1] + j_match[idx]);
				end else begin
					diag = clamp_score(h[i-1][j-1] - j_mis[idx]);
				end
				h[i][j] = larger(larger(0, diag), larger(e[i][j], f[i][j]));
				best = larger(best, h[i][j]);
			end
		end
		return best;
	endfunction

	task automatic report_mismatch(input string name, input int got, input int exp);
		errors++;
		$display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
	endtask

	task automatic make_random_job(input int idx);
		jq_len[idx]  = 1 + take_bits(3);
		jt_len[idx]  = 1 + take_bits(5);
		j_match[idx] = 1 + take_bits(3);
		j_mis[idx]   = take_bits(3);
		j_alpha[idx] = take_bits(3);
		j_beta[idx]  = take_bits(2);
		for (int k = 0; k < PE_COUNT; k++) begin
			jq[idx][k] = take_bits(2);
		end
		for (int k = 0; k < MAX_T_LEN; k++) begin
			jt[idx][k] = take_bits(2);
		end
	endtask

	// Starts and ends on a falling edge so jobs run back to back
	task automatic run_job(input int idx, input bit stalls, input bit poke, input int forced);
		int  expected;
		int  gap;
		int  waited;
		bit  got_valid;
		expected = (forced < 0) ? model_score(idx) : forced;
		i_start     = 1'b1;
		i_query_len = LEN_W'(jq_len[idx]);
		for (int k = 0; k < PE_COUNT; k++) begin
			i_query[k] = base_t'(jq[idx][k]);
		end
		i_match    = score_t'(j_match[idx]);
		i_mismatch = score_t'(j_mis[idx]);
		i_alpha    = score_t'(j_alpha[idx]);
		i_beta     = score_t'(j_beta[idx]);
		@(negedge clk);
		i_start = 1'b0;
		if (o_busy !== 1'b1) begin
			report_mismatch("o_busy", int'(o_busy), 1);
		end
		for (int j = 0; j < jt_len[idx]; j++) begin
			if (stalls && take_bits(1) == 1) begin
				gap = 1 + take_bits(2);
				repeat (gap) begin
					i_t_valid = 1'b0;
					i_t_last  = 1'b0;
					i_t_base  = base_t'(take_bits(2));
					@(negedge clk);
				end
			end
			i_t_valid = 1'b1;
			i_t_base  = base_t'(jt[idx][j]);
			i_t_last  = (j == jt_len[idx] - 1);
			// A start with other settings while busy must change nothing
			if (poke && j == jt_len[idx] / 2) begin
				i_start = 1'b1;
				i_query = ~i_query;
				i_match = score_t'(200);
				i_alpha = '0;
				i_beta  = '0;
			end
			@(negedge clk);
			i_start = 1'b0;
		end
		i_t_valid = 1'b0;
		i_t_last  = 1'b0;
		i_start   = poke;
		waited    = 0;
		got_valid = 1'b0;
		while (!got_valid && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
			if (o_valid === 1'b1) begin
				got_valid = 1'b1;
			end else if (o_busy !== 1'b1) begin
				report_mismatch("o_busy", int'(o_busy), 1);
			end
		end
		i_start = 1'b0;
		jobs_run++;
		if (!got_valid) begin
			errors++;
			$display("** Error at %0t: job %0d gave no o_valid within %0d cycles",
				$time, idx, WAIT_LIMIT);
		end else begin
			// The rising edge after this falling edge is the one that samples o_valid
			if (waited + 1 != jq_len[idx] + 3) begin
				report_mismatch("o_valid latency", waited + 1, jq_len[idx] + 3);
			end
			if (o_score !== score_t'(expected)) begin
				report_mismatch("o_score", int'(o_score), expected);
			end
			if (o_busy !== 1'b0) begin
				report_mismatch("o_busy", int'(o_busy), 0);
			end
		end
	endtask

	initial begin
		errors      = 0;
		jobs_run    = 0;
		lfsr_state  = 16'd47;
		i_start     = 1'b0;
		i_query     = '0;
		i_query_len = '0;
		i_match     = '0;
		i_mismatch  = '0;
		i_alpha     = '0;
		i_beta      = '0;
		i_t_base    = '0;
		i_t_valid   = 1'b0;
		i_t_last    = 1'b0;
		@(posedge rst_n);
		@(negedge clk);
		if (o_busy !== 1'b0) begin
			report_mismatch("o_busy", int'(o_busy), 0);
		end
		if (o_valid !== 1'b0) begin
			report_mismatch("o_valid", int'(o_valid), 0);
		end
		if (o_score !== '0) begin
			report_mismatch("o_score", int'(o_score), 0);
		end
		for (int n = 0; n < NUM_JOBS; n++) begin
			make_random_job(n);
		end
		for (int n = 0; n < RAND_JOBS; n++) begin
			run_job(n, 1'b0, 1'b0, -1);
		end
		// Same jobs with gaps in the target stream
		for (int n = 0; n < RAND_JOBS; n++) begin
			run_job(n, 1'b1, 1'b0, -1);
		end
		jq_len[40] = 1;
		jt_len[40] = MAX_T_LEN;
		jq_len[41] = PE_COUNT;
		jt_len[41] = 1;
		run_job(40, 1'b0, 1'b0, -1);
		run_job(41, 1'b1, 1'b0, -1);
		// Query copied into the middle of a full-length target
		jq_len[42]  = PE_COUNT;
		jt_len[42]  = MAX_T_LEN;
		j_match[42] = 5;
		for (int k = 0; k < PE_COUNT; k++) begin
			jt[42][10+k] = jq[42][k];
		end
		run_job(42, 1'b0, 1'b0, PE_COUNT * 5);
		jq_len[43] = 5;
		jt_len[43] = 12;
		for (int k = 0; k < PE_COUNT; k++) begin
			jq[43][k] = 0;
		end
		for (int k = 0; k < MAX_T_LEN; k++) begin
			jt[43][k] = (jt[43][k] == 0) ? 3 : jt[43][k];
		end
		run_job(43, 1'b0, 1'b0, 0);
		for (int n = 44; n < NUM_JOBS; n++) begin
			run_job(n, n[0], 1'b1, -1);
		end
		$display("Jobs run: %0d, errors: %0d", jobs_run, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with jobs still running", WATCHDOG_NS);
		$display("Jobs run: %0d, errors: %0d", jobs_run, errors);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/array_ctl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface array_ctl_if
	import sw_score_pkg::*;
	import sw_array_pkg::*;
();

	logic                 step;
	logic                 clear;
	logic [PE_COUNT-1:0]  pe_en;
	// One query base per element
	base_t [PE_COUNT-1:0] query;

	modport ctrl (
		output step,
		output clear,
		output pe_en,
		output query
	);

	modport chain (
		input step,
		input clear,
		input pe_en,
		input query
	);

endinterface

`default_nettype wire

// ==== verilog/pe_link_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface pe_link_if
	import sw_score_pkg::*;
();

	base_t  t_base;
	logic   t_vld;
	// H of the same column and of the column before
	score_t h_cur;
	score_t h_diag;
	score_t f;

	modport up (
		output t_base,
		output t_vld,
		output h_cur,
		output h_diag,
		output f
	);

	modport down (
		input t_base,
		input t_vld,
		input h_cur,
		input h_diag,
		input f
	);

endinterface

`default_nettype wire

// ==== verilog/sw_align_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sw_align_top
	import sw_score_pkg::*;
	import sw_array_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 i_start,
	input  base_t [PE_COUNT-1:0] i_query,
	input  logic  [LEN_W-1:0]    i_query_len,
	input  score_t               i_match,
	input  score_t               i_mismatch,
	input  score_t               i_alpha,
	input  score_t               i_beta,
	input  base_t                i_t_base,
	input  logic                 i_t_valid,
	input  logic                 i_t_last,
	output logic                 o_busy,
	output logic                 o_valid,
	output score_t               o_score
);

	array_ctl_if ctl_bus ();

	score_t                match_q;
	score_t                mismatch_q;
	score_t                alpha_q;
	score_t                beta_q;
	score_t [PE_COUNT-1:0] best_bus;
	logic                  tree_start;

	// Scores held for the whole job
	always_ff @(posedge clk) begin
		if (ctl_bus.clear) begin
			match_q    <= i_match;
			mismatch_q <= i_mismatch;
			alpha_q    <= i_alpha;
			beta_q     <= i_beta;
		end
	end

	sw_array_ctrl u_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_start      (i_start),
		.i_query      (i_query),
		.i_query_len  (i_query_len),
		.i_t_valid    (i_t_valid),
		.i_t_last     (i_t_last),
		.ctl          (ctl_bus.ctrl),
		.o_tree_start (tree_start),
		.o_busy       (o_busy)
	);

	sw_pe_chain u_chain (
		.clk        (clk),
		.rst_n      (rst_n),
		.ctl        (ctl_bus.chain),
		.i_t_base   (i_t_base),
		.i_t_vld    (i_t_valid),
		.i_match    (match_q),
		.i_mismatch (mismatch_q),
		.i_alpha    (alpha_q),
		.i_beta     (beta_q),
		.o_best_bus (best_bus)
	);

	sw_max_tree u_tree (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_best_bus (best_bus),
		.i_start    (tree_start),
		.o_vld      (o_valid),
		.o_score    (o_score)
	);

endmodule

`default_nettype wire

// ==== verilog/sw_array_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module sw_array_ctrl
	import sw_score_pkg::*;
	import sw_array_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 i_start,
	input  base_t [PE_COUNT-1:0] i_query,
	input  logic  [LEN_W-1:0]    i_query_len,
	input  logic                 i_t_valid,
	input  logic                 i_t_last,
	array_ctl_if.ctrl            ctl,
	output logic                 o_tree_start,
	output logic                 o_busy
);

	ctrl_state_t state;

	logic                 start_ok;
	logic                 tree_busy;
	logic                 tree_start;
	logic [PE_IDX_W-1:0]  last_idx;
	logic [PE_IDX_W-1:0]  drain_cnt;
	logic [T_CNT_W-1:0]   t_cnt;
	logic [PE_COUNT-1:0]  pe_en_q;
	base_t [PE_COUNT-1:0] query_q;

	// Reduction still running in the tree after ST_DONE
	logic [TREE_DEPTH-2:0] tree_pend;

	assign tree_busy  = |tree_pend;
	assign start_ok   = i_start && (state == ST_IDLE) && !tree_busy;
	assign tree_start = (state == ST_DONE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= ST_IDLE;
			last_idx  <= '0;
			drain_cnt <= '0;
			t_cnt     <= '0;
			pe_en_q   <= '0;
			tree_pend <= '0;
		end else begin
			tree_pend <= {tree_pend[TREE_DEPTH-3:0], tree_start};
			case (state)
				ST_IDLE: begin
					if (start_ok) begin
						state    <= ST_RUN;
						t_cnt    <= '0;
						last_idx <= PE_IDX_W'(i_query_len - 1'b1);
						for (int k = 0; k < PE_COUNT; k++) begin
							pe_en_q[k] <= (k < i_query_len);
						end
					end
				end
				ST_RUN: begin
					if (i_t_valid) begin
						t_cnt <= t_cnt + 1'b1;
						if (i_t_last) begin
							// Last element needs last_idx more steps
							if (last_idx == '0) begin
								state <= ST_DONE;
							end else begin
								state     <= ST_DRAIN;
								drain_cnt <= last_idx;
							end
						end
					end
				end
				ST_DRAIN: begin
					drain_cnt <= drain_cnt - 1'b1;
					if (drain_cnt == PE_IDX_W'(1)) begin
						state <= ST_DONE;
					end
				end
				ST_DONE: begin
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start_ok) begin
			query_q <= i_query;
		end
	end

	// Clear lands on the same edge that latches the new mask
	assign ctl.clear = start_ok;
	assign ctl.step  = ((state == ST_RUN) && i_t_valid) || (state == ST_DRAIN);
	assign ctl.pe_en = pe_en_q;
	assign ctl.query = query_q;

	assign o_tree_start = tree_start;
	assign o_busy       = (state != ST_IDLE) || tree_busy;

	a_query_len: assert property (
		@(posedge clk) disable iff (!rst_n)
		start_ok |-> (i_query_len >= 1) && (i_query_len <= PE_COUNT)
	);

	// Target longer than MAX_T_LEN
	a_t_len: assert property (
		@(posedge clk) disable iff (!rst_n)
		(state == ST_RUN) && i_t_valid |-> (t_cnt < MAX_T_LEN)
	);

endmodule

`default_nettype wire

// ==== verilog/sw_array_pkg.sv ====
`default_nettype none

package sw_array_pkg;

	// Array geometry
	localparam int PE_COUNT = 8;
	localparam int PE_IDX_W = 3;
	localparam int LEN_W    = PE_IDX_W + 1;

	// Longest target per job and width of the base counter
	localparam int MAX_T_LEN = 32;
	localparam int T_CNT_W   = 6;

	// Registered levels in the max tree
	localparam int TREE_DEPTH = 3;

	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_RUN   = 2'd1,
		ST_DRAIN = 2'd2,
		ST_DONE  = 2'd3
	} ctrl_state_t;

endpackage

`default_nettype wire

// ==== verilog/sw_max_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

module sw_max_tree
	import sw_score_pkg::*;
	import sw_array_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  score_t [PE_COUNT-1:0] i_best_bus,
	input  logic                  i_start,
	output logic                  o_vld,
	output score_t                o_score
);

	// Level d holds PE_COUNT >> (d+1) live entries
	score_t [PE_COUNT/2-1:0] lvl [TREE_DEPTH];
	logic   [TREE_DEPTH-1:0] vld;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lvl <= '{default: '0};
			vld <= '0;
		end else begin
			vld <= {vld[TREE_DEPTH-2:0], i_start};
			for (int k = 0; k < PE_COUNT / 2; k++) begin
				lvl[0][k] <= score_max(i_best_bus[2*k], i_best_bus[2*k+1]);
			end
			for (int d = 1; d < TREE_DEPTH; d++) begin
				for (int k = 0; k < (PE_COUNT >> (d + 1)); k++) begin
					lvl[d][k] <= score_max(lvl[d-1][2*k], lvl[d-1][2*k+1]);
				end
			end
		end
	end

	assign o_vld   = vld[TREE_DEPTH-1];
	assign o_score = lvl[TREE_DEPTH-1][0];

	// One result per job, the controller never starts twice in a row
	a_vld_pulse: assert property (
		@(posedge clk) disable iff (!rst_n)
		o_vld |=> !o_vld
	);

endmodule

`default_nettype wire

// ==== verilog/sw_pe.sv ====
`timescale 1ns/1ps
`default_nettype none

module sw_pe
	import sw_score_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	pe_link_if.down link_in,
	pe_link_if.up   link_out,
	input  logic    i_step,
	input  logic    i_clear,
	input  logic    i_en,
	input  base_t   i_q_base,
	input  score_t  i_match,
	input  score_t  i_mismatch,
	input  score_t  i_alpha,
	input  score_t  i_beta,
	output score_t  o_best
);

	logic   calc;
	score_t diag_sc;
	score_t e_new;
	score_t f_new;
	score_t h_new;

	// Own row state, H and E of the previous column
	score_t h_left;
	score_t e_left;
	score_t best;

	base_t  out_base;
	logic   out_vld;
	score_t out_h;
	score_t out_diag;
	score_t out_f;

	assign calc = i_step && i_en && link_in.t_vld;

	assign diag_sc = (link_in.t_base == i_q_base) ? sat_add(link_in.h_diag, i_match)
		: sat_sub(link_in.h_diag, i_mismatch);
	assign e_new = score_max(sat_sub(h_left, i_alpha), sat_sub(e_left, i_beta));
	assign f_new = score_max(sat_sub(link_in.h_cur, i_alpha), sat_sub(link_in.f, i_beta));
	// Unsigned terms, so the zero floor is implicit
	assign h_new = score_max(score_max(e_new, f_new), diag_sc);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			h_left   <= '0;
			e_left   <= '0;
			best     <= '0;
			out_base <= '0;
			out_vld  <= 1'b0;
			out_h    <= '0;
			out_diag <= '0;
			out_f    <= '0;
		end else if (i_clear) begin
			h_left   <= '0;
			e_left   <= '0;
			best     <= '0;
			out_base <= '0;
			out_vld  <= 1'b0;
			out_h    <= '0;
			out_diag <= '0;
			out_f    <= '0;
		end else if (i_step) begin
			out_vld <= calc;
			if (calc) begin
				h_left   <= h_new;
				e_left   <= e_new;
				best     <= score_max(best, h_new);
				out_base <= link_in.t_base;
				out_h    <= h_new;
				out_diag <= h_left;
				out_f    <= f_new;
			end
		end
	end

	assign link_out.t_base = out_base;
	assign link_out.t_vld  = out_vld;
	assign link_out.h_cur  = out_h;
	assign link_out.h_diag = out_diag;
	assign link_out.f      = out_f;
	assign o_best          = best;

	// Nothing valid leaves a disabled element, also across job boundaries
	a_no_vld_past_disabled: assert property (
		@(posedge clk) disable iff (!rst_n)
		!i_en |-> !out_vld
	);

endmodule

`default_nettype wire

// ==== verilog/sw_pe_chain.sv ====
`timescale 1ns/1ps
`default_nettype none

module sw_pe_chain
	import sw_score_pkg::*;
	import sw_array_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	array_ctl_if.chain            ctl,
	input  base_t                 i_t_base,
	input  logic                  i_t_vld,
	input  score_t                i_match,
	input  score_t                i_mismatch,
	input  score_t                i_alpha,
	input  score_t                i_beta,
	output score_t [PE_COUNT-1:0] o_best_bus
);

	pe_link_if link [PE_COUNT+1] ();

	// Target enters on a step only, border row is all zero
	assign link[0].t_base = i_t_base;
	assign link[0].t_vld  = i_t_vld && ctl.step;
	assign link[0].h_cur  = '0;
	assign link[0].h_diag = '0;
	assign link[0].f      = '0;

	generate
		for (genvar k = 0; k < PE_COUNT; k++) begin : g_pe
			sw_pe u_pe (
				.clk        (clk),
				.rst_n      (rst_n),
				.link_in    (link[k]),
				.link_out   (link[k+1]),
				.i_step     (ctl.step),
				.i_clear    (ctl.clear),
				.i_en       (ctl.pe_en[k]),
				.i_q_base   (ctl.query[k]),
				.i_match    (i_match),
				.i_mismatch (i_mismatch),
				.i_alpha    (i_alpha),
				.i_beta     (i_beta),
				.o_best     (o_best_bus[k])
			);
		end
	endgenerate

endmodule

`default_nettype wire

// ==== verilog/sw_score_pkg.sv ====
`default_nettype none

package sw_score_pkg;

	localparam int SCORE_W = 12;

	typedef logic [1:0]         base_t;
	typedef logic [SCORE_W-1:0] score_t;

	localparam score_t SCORE_MAX = '1;

	// Clamps at the top of the score range
	function automatic score_t sat_add(input score_t a, input score_t b);
		logic [SCORE_W:0] sum;
		sum = {1'b0, a} + {1'b0, b};
		return sum[SCORE_W] ? SCORE_MAX : sum[SCORE_W-1:0];
	endfunction

	// Clamps at zero
	function automatic score_t sat_sub(input score_t a, input score_t b);
		return (a > b) ? score_t'(a - b) : '0;
	endfunction

	function automatic score_t score_max(input score_t a, input score_t b);
		return (a > b) ? a : b;
	endfunction

endpackage

`default_nettype wire

// ==== vlog.f ====
verilog/sw_score_pkg.sv
verilog/sw_array_pkg.sv
verilog/pe_link_if.sv
verilog/array_ctl_if.sv
verilog/sw_pe.sv
verilog/sw_pe_chain.sv
verilog/sw_max_tree.sv
verilog/sw_array_ctrl.sv
verilog/sw_align_top.sv
tests/tb_clk_gen.sv
tests/tb_sw_align.sv
